// File: issue_pkg.sv
package issue_pkg;

    // field widths shared by the ROB payload and the uop format
    localparam int TAG_W     = 5;
    localparam int REG_W     = 5;
    localparam int FUNCT_W   = 6;
    localparam int OFFSET_W  = 11;
    localparam int IMM_W     = 16;
    localparam int PAYLOAD_W = 24;

    // functional unit classes with one ROB issue port each
    typedef enum logic [1:0] {
        CLASS_LSU = 2'd0,
        CLASS_BRU = 2'd1,
        CLASS_ALU = 2'd2,
        CLASS_FPU = 2'd3
    } unit_class_e;

    // ROB entry index carried through to the unit untouched
    typedef logic [TAG_W-1:0] rob_tag_t;

    // architectural register index
    typedef logic [REG_W-1:0] reg_idx_t;

    // memory view of the payload word
    typedef struct packed {
        // 1 = store, 0 = load
        logic                        is_store;
        // access size, log2 of bytes
        logic [1:0]                  size;
        // load destination or store source
        reg_idx_t                    data_reg;
        // address base register
        reg_idx_t                    base_reg;
        // byte offset from base
        logic signed [OFFSET_W-1:0]  offset;
    } mem_op_t;

    // arithmetic view of the payload word
    typedef struct packed {
        // operation select, decoded by the unit
        logic [FUNCT_W-1:0] funct;
        reg_idx_t           dst;
        reg_idx_t           src1;
        reg_idx_t           src2;
        // spare bits, ignored
        logic [2:0]         rsvd;
    } arith_op_t;

    // same 24 bits read as mem op on the lsu port
    // and as arith op everywhere else
    typedef union packed {
        mem_op_t   mem;
        arith_op_t arith;
    } op_payload_u;

    // one instruction offered by the ROB
    typedef struct packed {
        logic        valid;
        rob_tag_t    tag;
        op_payload_u payload;
    } rob_issue;

    // expanded micro-op as seen by a functional unit
    typedef struct packed {
        rob_tag_t           tag;
        // memory access flag and its qualifiers
        logic               is_mem;
        logic               is_store;
        logic [1:0]         size;
        // operation and operand registers
        logic [FUNCT_W-1:0] funct;
        reg_idx_t           dst;
        reg_idx_t           src1;
        reg_idx_t           src2;
        // sign-extended immediate for lsu only
        logic [IMM_W-1:0]   imm;
    } uop_insn;

endpackage

// File: fu_queue.sv
`timescale 1ns/1ps

module fu_queue import issue_pkg::*; #(
    parameter int Q_DEPTH = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    // push side from the steering logic
    input  logic     enq_valid,
    input  rob_issue enq_data,
    // pop side towards the unit
    input  logic     deq_ready,
    output logic     deq_valid,
    output rob_issue deq_data,
    output logic     full
);

    // pointer width is at least one bit even for a single entry
    localparam int PTR_W = (Q_DEPTH > 1) ? $clog2(Q_DEPTH) : 1;
    // count has to reach Q_DEPTH itself
    localparam int CNT_W = $clog2(Q_DEPTH + 1);

    rob_issue         mem [Q_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count == CNT_W'(Q_DEPTH));
    assign empty = (count == '0);

    // full/empty guard both ends
    assign push = enq_valid && !full;
    assign pop  = deq_ready && !empty;

    // head is visible as soon as it is written
    assign deq_valid = !empty;
    assign deq_data  = mem[head];

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= enq_data;
        end
    end

    // flush wins over a same-cycle push
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= (tail == PTR_W'(Q_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) begin
                head <= (head == PTR_W'(Q_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            // push and pop together leave count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: uop_expand.sv
`timescale 1ns/1ps

module uop_expand import issue_pkg::*; #(
    parameter unit_class_e UNIT_CLASS = CLASS_ALU
) (
    input  rob_issue entry,
    output uop_insn  uop
);

    mem_op_t   m;
    arith_op_t a;

    // two readings of the same payload word
    assign m = entry.payload.mem;
    assign a = entry.payload.arith;

    always_comb begin
        // tag passes straight through
        uop     = '0;
        uop.tag = entry.tag;

        if (UNIT_CLASS == CLASS_LSU) begin
            uop.is_mem   = 1'b1;
            uop.is_store = m.is_store;
            uop.size     = m.size;
            uop.funct    = '0;
            // address always from base
            uop.src1     = m.base_reg;
            if (m.is_store) begin
                // store reads the data register
                uop.dst  = '0;
                uop.src2 = m.data_reg;
            end else begin
                // load writes the data register
                uop.dst  = m.data_reg;
                uop.src2 = '0;
            end
            // sign-extend offset to imm width
            uop.imm = {{(IMM_W - OFFSET_W){m.offset[OFFSET_W-1]}}, m.offset};
        end else begin
            // plain register op for bru, alu and fpu
            uop.is_mem   = 1'b0;
            uop.is_store = 1'b0;
            uop.size     = '0;
            uop.funct    = a.funct;
            uop.dst      = a.dst;
            uop.src1     = a.src1;
            uop.src2     = a.src2;
            // no immediate here
            uop.imm      = '0;
        end
    end

endmodule

// File: issue_class.sv
`timescale 1ns/1ps

module issue_class import issue_pkg::*; #(
    parameter int          Q_DEPTH    = 4,
    parameter int          NUM_UNITS  = 2,
    parameter unit_class_e UNIT_CLASS = CLASS_ALU
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    // ROB side
    input  rob_issue                      insn,
    output logic                          ready,
    // unit side with one lane per functional unit
    input  logic [NUM_UNITS-1:0]          unit_ready,
    output uop_insn [NUM_UNITS-1:0]       unit_uop,
    output logic [NUM_UNITS-1:0]          unit_valid
);

    // per-queue status
    logic [NUM_UNITS-1:0]     q_full;
    // one-hot target of the next push
    logic [NUM_UNITS-1:0]     enq_sel;
    logic [NUM_UNITS-1:0]     enq_valid;
    // queue heads before expansion
    rob_issue [NUM_UNITS-1:0] head_entry;

    // lowest non-full queue wins
    always_comb begin
        logic found;
        found   = 1'b0;
        enq_sel = '0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (!q_full[i] && !found) begin
                enq_sel[i] = 1'b1;
                found      = 1'b1;
            end
        end
    end

    // room somewhere in the class
    assign ready = |(~q_full);

    // push only into the picked queue
    // flush inside the queue drops a same-cycle offer
    assign enq_valid = enq_sel & {NUM_UNITS{insn.valid}};

    for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
        // one FIFO per unit
        fu_queue #(
            .Q_DEPTH (Q_DEPTH)
        ) i_queue (
            .clk       (clk),
            .reset     (reset),
            .flush     (flush),
            .enq_valid (enq_valid[i]),
            .enq_data  (insn),
            .deq_ready (unit_ready[i]),
            .deq_valid (unit_valid[i]),
            .deq_data  (head_entry[i]),
            .full      (q_full[i])
        );

        // head to uop format for this class
        uop_expand #(
            .UNIT_CLASS (UNIT_CLASS)
        ) i_expand (
            .entry (head_entry[i]),
            .uop   (unit_uop[i])
        );
    end

endmodule

// File: instruction_scheduler.sv
`timescale 1ns/1ps

module instruction_scheduler import issue_pkg::*; #(
    // entries per unit queue
    parameter int Q_DEPTH   = 4,
    // functional units per class
    parameter int NUM_UNITS = 2
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    // one offered instruction per class from the ROB
    input  rob_issue                lsu_insn,
    input  rob_issue                bru_insn,
    input  rob_issue                alu_insn,
    input  rob_issue                fpu_insn,
    // back-pressure from the units
    input  logic [NUM_UNITS-1:0]    lsu_unit_ready,
    input  logic [NUM_UNITS-1:0]    bru_unit_ready,
    input  logic [NUM_UNITS-1:0]    alu_unit_ready,
    input  logic [NUM_UNITS-1:0]    fpu_unit_ready,
    // class can take an instruction
    output logic                    lsu_ready,
    output logic                    bru_ready,
    output logic                    alu_ready,
    output logic                    fpu_ready,
    // expanded queue heads
    output uop_insn [NUM_UNITS-1:0] lsu_uop,
    output uop_insn [NUM_UNITS-1:0] bru_uop,
    output uop_insn [NUM_UNITS-1:0] alu_uop,
    output uop_insn [NUM_UNITS-1:0] fpu_uop,
    output logic [NUM_UNITS-1:0]    lsu_uop_valid,
    output logic [NUM_UNITS-1:0]    bru_uop_valid,
    output logic [NUM_UNITS-1:0]    alu_uop_valid,
    output logic [NUM_UNITS-1:0]    fpu_uop_valid
);

    // load/store with the payload read as mem op
    issue_class #(
        .Q_DEPTH (Q_DEPTH), .NUM_UNITS (NUM_UNITS), .UNIT_CLASS (CLASS_LSU)
    ) i_lsu (
        .clk (clk), .reset (reset), .flush (flush),
        .insn (lsu_insn), .ready (lsu_ready),
        .unit_ready (lsu_unit_ready), .unit_uop (lsu_uop), .unit_valid (lsu_uop_valid)
    );

    // branch
    issue_class #(
        .Q_DEPTH (Q_DEPTH), .NUM_UNITS (NUM_UNITS), .UNIT_CLASS (CLASS_BRU)
    ) i_bru (
        .clk (clk), .reset (reset), .flush (flush),
        .insn (bru_insn), .ready (bru_ready),
        .unit_ready (bru_unit_ready), .unit_uop (bru_uop), .unit_valid (bru_uop_valid)
    );

    // integer
    issue_class #(
        .Q_DEPTH (Q_DEPTH), .NUM_UNITS (NUM_UNITS), .UNIT_CLASS (CLASS_ALU)
    ) i_alu (
        .clk (clk), .reset (reset), .flush (flush),
        .insn (alu_insn), .ready (alu_ready),
        .unit_ready (alu_unit_ready), .unit_uop (alu_uop), .unit_valid (alu_uop_valid)
    );

    // floating point
    issue_class #(
        .Q_DEPTH (Q_DEPTH), .NUM_UNITS (NUM_UNITS), .UNIT_CLASS (CLASS_FPU)
    ) i_fpu (
        .clk (clk), .reset (reset), .flush (flush),
        .insn (fpu_insn), .ready (fpu_ready),
        .unit_ready (fpu_unit_ready), .unit_uop (fpu_uop), .unit_valid (fpu_uop_valid)
    );

endmodule

// File: tb_instruction_scheduler.sv
`timescale 1ns/1ps

module tb_instruction_scheduler import issue_pkg::*; ();

    localparam int Q_DEPTH     = 4;
    localparam int NUM_UNITS   = 2;
    // one model queue per unit in class-major order
    localparam int NUM_Q       = 4 * NUM_UNITS;
    // cycles allowed for all queues to empty
    localparam int DRAIN_LIMIT = 200;
    localparam int RAND_CYCLES = 500;

    logic clk = 1'b0;
    logic reset;
    logic flush;

    // per-class drive and monitor arrays indexed by unit class
    rob_issue                insn_drv   [4];
    logic [NUM_UNITS-1:0]    urdy_drv   [4];
    logic                    rdy_mon    [4];
    uop_insn [NUM_UNITS-1:0] uop_mon    [4];
    logic [NUM_UNITS-1:0]    uvalid_mon [4];

    // expected uops still held by each unit queue
    uop_insn     model_q [NUM_Q][$];
    logic [31:0] rng_state = 32'hae1e;

    always #2 clk = ~clk;

    instruction_scheduler #(
        .Q_DEPTH   (Q_DEPTH),
        .NUM_UNITS (NUM_UNITS)
    ) i_dut (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .lsu_insn       (insn_drv[0]),
        .bru_insn       (insn_drv[1]),
        .alu_insn       (insn_drv[2]),
        .fpu_insn       (insn_drv[3]),
        .lsu_unit_ready (urdy_drv[0]),
        .bru_unit_ready (urdy_drv[1]),
        .alu_unit_ready (urdy_drv[2]),
        .fpu_unit_ready (urdy_drv[3]),
        .lsu_ready      (rdy_mon[0]),
        .bru_ready      (rdy_mon[1]),
        .alu_ready      (rdy_mon[2]),
        .fpu_ready      (rdy_mon[3]),
        .lsu_uop        (uop_mon[0]),
        .bru_uop        (uop_mon[1]),
        .alu_uop        (uop_mon[2]),
        .fpu_uop        (uop_mon[3]),
        .lsu_uop_valid  (uvalid_mon[0]),
        .bru_uop_valid  (uvalid_mon[1]),
        .alu_uop_valid  (uvalid_mon[2]),
        .fpu_uop_valid  (uvalid_mon[3])
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // expansion rule from the raw payload bit positions
    function automatic uop_insn expected_uop(input int c, input rob_issue r);
        uop_insn              e;
        logic [PAYLOAD_W-1:0] p;
        e     = '0;
        p     = r.payload;
        e.tag = r.tag;
        if (c == 0) begin
            e.is_mem   = 1'b1;
            e.is_store = p[23];
            e.size     = p[22:21];
            e.src1     = p[15:11];
            // data reg goes to src2 on a store and to dst on a load
            if (p[23]) begin
                e.src2 = p[20:16];
            end else begin
                e.dst = p[20:16];
            end
            e.imm = {{5{p[10]}}, p[10:0]};
        end else begin
            e.funct = p[23:18];
            e.dst   = p[17:13];
            e.src1  = p[12:8];
            e.src2  = p[7:3];
        end
        return e;
    endfunction

    function automatic rob_issue arith_insn(input logic [4:0] tag, input logic [5:0] funct,
                                            input logic [4:0] dst, input logic [4:0] src1,
                                            input logic [4:0] src2);
        rob_issue r;
        r                     = '0;
        r.valid               = 1'b1;
        r.tag                 = tag;
        r.payload.arith.funct = funct;
        r.payload.arith.dst   = dst;
        r.payload.arith.src1  = src1;
        r.payload.arith.src2  = src2;
        return r;
    endfunction

    function automatic rob_issue mem_insn(input logic [4:0] tag, input logic is_store,
                                          input logic [1:0] size, input logic [4:0] data_reg,
                                          input logic [4:0] base_reg, input logic [10:0] offset);
        rob_issue r;
        r                      = '0;
        r.valid                = 1'b1;
        r.tag                  = tag;
        r.payload.mem.is_store = is_store;
        r.payload.mem.size     = size;
        r.payload.mem.data_reg = data_reg;
        r.payload.mem.base_reg = base_reg;
        r.payload.mem.offset   = offset;
        return r;
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic idle_inputs();
        for (int c = 0; c < 4; c++) begin
            insn_drv[c] = '0;
        end
        flush = 1'b0;
    endtask

    // compare outputs with the model and update it for the coming edge
    // then advance to the next falling edge
    task automatic cycle();
        int q;
        int tgt;
        bit room;
        for (int c = 0; c < 4; c++) begin
            room = 1'b0;
            tgt  = -1;
            for (int u = 0; u < NUM_UNITS; u++) begin
                q = c * NUM_UNITS + u;
                check(64'(uvalid_mon[c][u]), 64'(model_q[q].size() != 0),
                      $sformatf("class %0d unit %0d uop_valid", c, u));
                if (model_q[q].size() != 0) begin
                    check(64'(uop_mon[c][u]), 64'(model_q[q][0]),
                          $sformatf("class %0d unit %0d uop", c, u));
                end
                // steering sees the full flags before this edge's pops
                if (model_q[q].size() < Q_DEPTH) begin
                    room = 1'b1;
                    if (tgt < 0) begin
                        tgt = u;
                    end
                end
            end
            check(64'(rdy_mon[c]), 64'(room), $sformatf("class %0d ready", c));
            for (int u = 0; u < NUM_UNITS; u++) begin
                q = c * NUM_UNITS + u;
                if (model_q[q].size() != 0 && urdy_drv[c][u]) begin
                    void'(model_q[q].pop_front());
                end
            end
            if (flush) begin
                for (int u = 0; u < NUM_UNITS; u++) begin
                    model_q[c * NUM_UNITS + u].delete();
                end
            end else if (insn_drv[c].valid && tgt >= 0) begin
                model_q[c * NUM_UNITS + tgt].push_back(expected_uop(c, insn_drv[c]));
            end
        end
        @(posedge clk);
        @(negedge clk);
    endtask

    // release every unit until all model queues are empty
    task automatic drain();
        int  n;
        bit  busy;
        idle_inputs();
        for (int c = 0; c < 4; c++) begin
            urdy_drv[c] = '1;
        end
        n    = 0;
        busy = 1'b1;
        while (busy) begin
            busy = 1'b0;
            for (int q = 0; q < NUM_Q; q++) begin
                if (model_q[q].size() != 0) begin
                    busy = 1'b1;
                end
            end
            if (busy && n == DRAIN_LIMIT) begin
                $display("SIMULATION FAILED");
                $fatal(1, "unit queues did not drain within %0d cycles", DRAIN_LIMIT);
            end else if (busy) begin
                cycle();
                n++;
            end
        end
        // one more look at the empty state
        cycle();
    endtask

    task automatic reset_state();
        for (int c = 0; c < 4; c++) begin
            check(64'(uvalid_mon[c]), 64'(0), $sformatf("class %0d uop_valid after reset", c));
            check(64'(rdy_mon[c]), 64'(1), $sformatf("class %0d ready after reset", c));
        end
        cycle();
    endtask

    task automatic arith_path();
        for (int c = 0; c < 4; c++) begin
            urdy_drv[c] = '0;
        end
        insn_drv[1] = arith_insn(5'd17, 6'h2a, 5'd1, 5'd2, 5'd3);
        insn_drv[2] = arith_insn(5'd18, 6'h15, 5'd31, 5'd0, 5'd30);
        insn_drv[3] = arith_insn(5'd19, 6'h3f, 5'd8, 5'd9, 5'd10);
        cycle();
        idle_inputs();
        // visible on unit 0 right after the accepting edge
        for (int c = 1; c < 4; c++) begin
            check(64'(uvalid_mon[c][0]), 64'(1), $sformatf("class %0d unit 0 valid", c));
            check(64'(uop_mon[c][0].tag), 64'(16 + c), $sformatf("class %0d tag", c));
            check(64'(uop_mon[c][0].imm), 64'(0), $sformatf("class %0d imm", c));
            check(64'(uop_mon[c][0].is_mem), 64'(0), $sformatf("class %0d is_mem", c));
        end
        check(64'(uop_mon[2][0].dst), 64'(31), "alu dst");
        check(64'(uop_mon[2][0].src2), 64'(30), "alu src2");
        check(64'(uop_mon[3][0].funct), 64'(6'h3f), "fpu funct");
        drain();
    endtask

    task automatic lsu_expansion();
        urdy_drv[0] = '0;
        // load with offset -5
        insn_drv[0] = mem_insn(5'd3, 1'b0, 2'd2, 5'd7, 5'd9, 11'h7fb);
        cycle();
        // store with offset -1024
        insn_drv[0] = mem_insn(5'd4, 1'b1, 2'd3, 5'd12, 5'd2, 11'h400);
        cycle();
        idle_inputs();
        check(64'(uop_mon[0][0].dst), 64'(7), "load dst");
        check(64'(uop_mon[0][0].src2), 64'(0), "load src2");
        check(64'(uop_mon[0][0].src1), 64'(9), "load base");
        check(64'(uop_mon[0][0].imm), 64'(16'hfffb), "load imm");
        check(64'(uop_mon[0][0].is_store), 64'(0), "load is_store");
        // pop the load so the store moves to head
        urdy_drv[0] = 2'b01;
        cycle();
        urdy_drv[0] = '0;
        check(64'(uop_mon[0][0].dst), 64'(0), "store dst");
        check(64'(uop_mon[0][0].src2), 64'(12), "store src2");
        check(64'(uop_mon[0][0].imm), 64'(16'hfc00), "store imm");
        check(64'(uop_mon[0][0].is_store), 64'(1), "store is_store");
        check(64'(uop_mon[0][0].size), 64'(3), "store size");
        drain();
    endtask

    // fill both alu queues with the units stalled
    task automatic fill_and_drain();
        logic [31:0] r;
        urdy_drv[2] = '0;
        for (int i = 0; i < 2 * Q_DEPTH; i++) begin
            check(64'(rdy_mon[2]), 64'(1), "alu ready while filling");
            if (i == Q_DEPTH) begin
                check(64'(uvalid_mon[2][1]), 64'(0), "alu unit 1 idle until queue 0 full");
            end
            r           = next_rand();
            insn_drv[2] = arith_insn(5'(i), r[5:0], r[10:6], r[15:11], r[20:16]);
            cycle();
        end
        idle_inputs();
        check(64'(rdy_mon[2]), 64'(0), "alu ready with all queues full");
        check(64'(uvalid_mon[2]), 64'({NUM_UNITS{1'b1}}), "alu valid with all queues full");
        drain();
    endtask

    task automatic flush_all();
        for (int c = 0; c < 4; c++) begin
            urdy_drv[c] = '0;
        end
        // lsu queue partly filled and both alu queues full
        for (int i = 0; i < 2 * Q_DEPTH; i++) begin
            if (i < 3) begin
                insn_drv[0] = mem_insn(5'(i), 1'b0, 2'd1, 5'd4, 5'd5, 11'h010);
            end else begin
                insn_drv[0] = '0;
            end
            insn_drv[2] = arith_insn(5'(8 + i), 6'h01, 5'd1, 5'd1, 5'd1);
            cycle();
        end
        idle_inputs();
        check(64'(rdy_mon[2]), 64'(0), "alu ready before flush");
        // offered together with the flush and dropped
        insn_drv[1] = arith_insn(5'd27, 6'h11, 5'd2, 5'd3, 5'd4);
        insn_drv[2] = arith_insn(5'd28, 6'h12, 5'd5, 5'd6, 5'd7);
        flush       = 1'b1;
        cycle();
        idle_inputs();
        for (int c = 0; c < 4; c++) begin
            check(64'(uvalid_mon[c]), 64'(0), $sformatf("class %0d valid after flush", c));
            check(64'(rdy_mon[c]), 64'(1), $sformatf("class %0d ready after flush", c));
            urdy_drv[c] = '1;
        end
        // nothing may surface afterwards
        repeat (4) cycle();
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [31:0] p;
        for (int n = 0; n < RAND_CYCLES; n++) begin
            for (int c = 0; c < 4; c++) begin
                r                   = next_rand();
                p                   = next_rand();
                insn_drv[c]         = '0;
                insn_drv[c].valid   = r[0] | r[1];
                insn_drv[c].tag     = r[6:2];
                insn_drv[c].payload = p[23:0];
                urdy_drv[c]         = r[8 +: NUM_UNITS] | r[12 +: NUM_UNITS];
            end
            cycle();
        end
        drain();
    endtask

    initial begin
        reset = 1'b1;
        idle_inputs();
        for (int c = 0; c < 4; c++) begin
            urdy_drv[c] = '0;
        end
        repeat (8) @(negedge clk);
        reset = 1'b0;
        reset_state();
        arith_path();
        lsu_expansion();
        fill_and_drain();
        flush_all();
        random_traffic();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: sources.f
issue_pkg.sv
fu_queue.sv
uop_expand.sv
issue_class.sv
instruction_scheduler.sv
tb_instruction_scheduler.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_instruction_scheduler
FILELIST   := sources.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SIM        := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

# build, then run; a $fatal in the testbench gives a failing exit status
all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(SIM)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
